/* Makefile */
TOP := tb_roce_tx_header_producer
SIM := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): verilog.f $(wildcard rtl/*.sv verif/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf obj_dir

/* rtl/roce_tx_header_gen.sv */
`timescale 1ns/1ps

module roce_tx_header_gen
    import roce_tx_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        meta_load,
    input  qpn_t        rem_qpn,
    input  qpn_t        loc_qpn,
    input  psn_t        rem_psn,
    input  rkey_t       r_key,
    input  ip_addr_t    rem_ip_addr,
    input  udp_port_t   src_udp_port,
    input  vaddr_t      rem_addr,
    input  dma_len_t    dma_length,
    input  logic        is_immediate,
    input  logic [31:0] immediate_data,
    input  logic        transfer_type,
    input  udp_port_t   roce_udp_port,
    input  logic        pkt_start,
    input  logic        pkt_first,
    input  logic        pkt_last,
    input  pkt_len_t    pkt_len,
    output logic        hdr_busy,
    output logic        m_roce_bth_valid,
    input  logic        m_roce_bth_ready,
    output opcode_t     m_roce_bth_op_code,
    output logic [15:0] m_roce_bth_p_key,
    output psn_t        m_roce_bth_psn,
    output qpn_t        m_roce_bth_dest_qp,
    output qpn_t        m_roce_bth_src_qp,
    output logic        m_roce_bth_ack_req,
    output ip_addr_t    m_ip_dest_ip,
    output udp_port_t   m_udp_source_port,
    output udp_port_t   m_udp_dest_port,
    output logic [15:0] m_udp_length,
    output logic        m_roce_reth_valid,
    input  logic        m_roce_reth_ready,
    output vaddr_t      m_roce_reth_v_addr,
    output rkey_t       m_roce_reth_r_key,
    output dma_len_t    m_roce_reth_length,
    output logic        m_roce_immdh_valid,
    input  logic        m_roce_immdh_ready,
    output logic [31:0] m_roce_immdh_data
);

    psn_t        rem_psn_q;
    logic        write_q;
    logic        imm_q;
    logic        send_reth;
    logic        send_immdh;
    opcode_t     op_next;
    psn_t        psn_next;
    logic [15:0] udp_len_next;

    // descriptor fields stay put until every header of the transfer has left
    always_ff @(posedge clk) begin
        if (meta_load) begin
            rem_psn_q          <= rem_psn;
            write_q            <= transfer_type;
            imm_q              <= is_immediate;
            m_roce_bth_dest_qp <= rem_qpn;
            m_roce_bth_src_qp  <= loc_qpn;
            m_ip_dest_ip       <= rem_ip_addr;
            m_udp_source_port  <= src_udp_port;
            m_roce_reth_v_addr <= rem_addr;
            m_roce_reth_r_key  <= r_key;
            m_roce_reth_length <= dma_length;
            m_roce_immdh_data  <= immediate_data;
        end
    end

    always_comb begin
        send_reth  = write_q && pkt_first;
        send_immdh = imm_q && pkt_last;
        psn_next   = pkt_first ? rem_psn_q : m_roce_bth_psn + psn_t'(1);

        if (pkt_first && pkt_last) begin
            if (write_q) begin
                op_next = send_immdh ? RC_RDMA_WRITE_ONLY_IMD : RC_RDMA_WRITE_ONLY;
            end else begin
                op_next = send_immdh ? RC_SEND_ONLY_IMD : RC_SEND_ONLY;
            end
        end else if (pkt_first) begin
            op_next = write_q ? RC_RDMA_WRITE_FIRST : RC_SEND_FIRST;
        end else if (pkt_last) begin
            if (write_q) begin
                op_next = send_immdh ? RC_RDMA_WRITE_LAST_IMD : RC_RDMA_WRITE_LAST;
            end else begin
                op_next = send_immdh ? RC_SEND_LAST_IMD : RC_SEND_LAST;
            end
        end else begin
            op_next = write_q ? RC_RDMA_WRITE_MIDDLE : RC_SEND_MIDDLE;
        end

        // payload plus udp header, bth and the optional extension headers
        udp_len_next = 16'(pkt_len) + 16'(UDP_HDR_BYTES + BTH_BYTES);
        if (send_reth) begin
            udp_len_next = udp_len_next + 16'(RETH_BYTES);
        end
        if (send_immdh) begin
            udp_len_next = udp_len_next + 16'(IMMDH_BYTES);
        end
    end

    always_ff @(posedge clk) begin
        if (pkt_start) begin
            m_roce_bth_op_code <= op_next;
            m_roce_bth_psn     <= psn_next;
            m_udp_length       <= udp_len_next;
            m_udp_dest_port    <= roce_udp_port;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_roce_bth_valid   <= 1'b0;
            m_roce_reth_valid  <= 1'b0;
            m_roce_immdh_valid <= 1'b0;
        end else if (pkt_start) begin
            m_roce_bth_valid   <= 1'b1;
            m_roce_reth_valid  <= send_reth;
            m_roce_immdh_valid <= send_immdh;
        end else begin
            m_roce_bth_valid   <= m_roce_bth_valid && !m_roce_bth_ready;
            m_roce_reth_valid  <= m_roce_reth_valid && !m_roce_reth_ready;
            m_roce_immdh_valid <= m_roce_immdh_valid && !m_roce_immdh_ready;
        end
    end

    assign hdr_busy = m_roce_bth_valid || m_roce_reth_valid || m_roce_immdh_valid;

    assign m_roce_bth_p_key   = DEFAULT_P_KEY;
    assign m_roce_bth_ack_req = 1'b1;

endmodule

/* rtl/roce_tx_header_producer.sv */
`timescale 1ns/1ps

module roce_tx_header_producer
    import roce_tx_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // descriptor
    input  logic        s_dma_meta_valid,
    output logic        s_dma_meta_ready,
    input  dma_len_t    dma_length,
    input  qpn_t        rem_qpn,
    input  qpn_t        loc_qpn,
    input  psn_t        rem_psn,
    input  rkey_t       r_key,
    input  ip_addr_t    rem_ip_addr,
    input  udp_port_t   src_udp_port,
    input  vaddr_t      rem_addr,
    input  logic        is_immediate,
    input  logic [31:0] immediate_data,
    input  logic        transfer_type,
    // payload in
    input  data_t       s_axis_tdata,
    input  keep_t       s_axis_tkeep,
    input  logic        s_axis_tvalid,
    output logic        s_axis_tready,
    // bth with ip and udp fields
    output logic        m_roce_bth_valid,
    input  logic        m_roce_bth_ready,
    output opcode_t     m_roce_bth_op_code,
    output logic [15:0] m_roce_bth_p_key,
    output psn_t        m_roce_bth_psn,
    output qpn_t        m_roce_bth_dest_qp,
    output qpn_t        m_roce_bth_src_qp,
    output logic        m_roce_bth_ack_req,
    output ip_addr_t    m_ip_dest_ip,
    output udp_port_t   m_udp_source_port,
    output udp_port_t   m_udp_dest_port,
    output logic [15:0] m_udp_length,
    // reth
    output logic        m_roce_reth_valid,
    input  logic        m_roce_reth_ready,
    output vaddr_t      m_roce_reth_v_addr,
    output rkey_t       m_roce_reth_r_key,
    output dma_len_t    m_roce_reth_length,
    // immdh
    output logic        m_roce_immdh_valid,
    input  logic        m_roce_immdh_ready,
    output logic [31:0] m_roce_immdh_data,
    // payload out
    output data_t       m_roce_payload_axis_tdata,
    output keep_t       m_roce_payload_axis_tkeep,
    output logic        m_roce_payload_axis_tvalid,
    input  logic        m_roce_payload_axis_tready,
    output logic        m_roce_payload_axis_tlast,
    // static config
    input  pmtu_code_t  pmtu,
    input  udp_port_t   roce_udp_port
);

    logic     meta_load;
    logic     hdr_busy;
    logic     pkt_start;
    logic     pkt_first;
    logic     pkt_last;
    pkt_len_t pkt_len;
    logic     int_valid;
    data_t    int_data;
    keep_t    int_keep;
    logic     int_last;
    logic     int_ready_early;

    roce_tx_segmenter u_segmenter (
        .clk,
        .rst,
        .s_dma_meta_valid,
        .s_dma_meta_ready,
        .dma_length,
        .pmtu,
        .s_axis_tdata,
        .s_axis_tkeep,
        .s_axis_tvalid,
        .s_axis_tready,
        .hdr_busy,
        .meta_load,
        .pkt_start,
        .pkt_first,
        .pkt_last,
        .pkt_len,
        .int_valid,
        .int_data,
        .int_keep,
        .int_last,
        .int_ready_early
    );

    roce_tx_header_gen u_header_gen (
        .clk,
        .rst,
        .meta_load,
        .rem_qpn,
        .loc_qpn,
        .rem_psn,
        .r_key,
        .rem_ip_addr,
        .src_udp_port,
        .rem_addr,
        .dma_length,
        .is_immediate,
        .immediate_data,
        .transfer_type,
        .roce_udp_port,
        .pkt_start,
        .pkt_first,
        .pkt_last,
        .pkt_len,
        .hdr_busy,
        .m_roce_bth_valid,
        .m_roce_bth_ready,
        .m_roce_bth_op_code,
        .m_roce_bth_p_key,
        .m_roce_bth_psn,
        .m_roce_bth_dest_qp,
        .m_roce_bth_src_qp,
        .m_roce_bth_ack_req,
        .m_ip_dest_ip,
        .m_udp_source_port,
        .m_udp_dest_port,
        .m_udp_length,
        .m_roce_reth_valid,
        .m_roce_reth_ready,
        .m_roce_reth_v_addr,
        .m_roce_reth_r_key,
        .m_roce_reth_length,
        .m_roce_immdh_valid,
        .m_roce_immdh_ready,
        .m_roce_immdh_data
    );

    roce_tx_skid_buffer u_skid_buffer (
        .clk,
        .rst,
        .int_valid,
        .int_data,
        .int_keep,
        .int_last,
        .int_ready_early,
        .m_tdata  (m_roce_payload_axis_tdata),
        .m_tkeep  (m_roce_payload_axis_tkeep),
        .m_tvalid (m_roce_payload_axis_tvalid),
        .m_tlast  (m_roce_payload_axis_tlast),
        .m_tready (m_roce_payload_axis_tready)
    );

endmodule

/* rtl/roce_tx_pkg.sv */
package roce_tx_pkg;

    localparam int DATA_WIDTH = 64;
    localparam int DATA_BYTES = DATA_WIDTH / 8;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [DATA_BYTES-1:0] keep_t;
    typedef logic [23:0] qpn_t;
    typedef logic [23:0] psn_t;
    typedef logic [31:0] rkey_t;
    typedef logic [63:0] vaddr_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [31:0] dma_len_t;
    typedef logic [13:0] pkt_len_t;
    typedef logic [2:0]  pmtu_code_t;
    typedef logic [7:0]  opcode_t;

    // reliable connection opcodes
    localparam opcode_t RC_SEND_FIRST          = 8'h00;
    localparam opcode_t RC_SEND_MIDDLE         = 8'h01;
    localparam opcode_t RC_SEND_LAST           = 8'h02;
    localparam opcode_t RC_SEND_LAST_IMD       = 8'h03;
    localparam opcode_t RC_SEND_ONLY           = 8'h04;
    localparam opcode_t RC_SEND_ONLY_IMD       = 8'h05;
    localparam opcode_t RC_RDMA_WRITE_FIRST    = 8'h06;
    localparam opcode_t RC_RDMA_WRITE_MIDDLE   = 8'h07;
    localparam opcode_t RC_RDMA_WRITE_LAST     = 8'h08;
    localparam opcode_t RC_RDMA_WRITE_LAST_IMD = 8'h09;
    localparam opcode_t RC_RDMA_WRITE_ONLY     = 8'h0A;
    localparam opcode_t RC_RDMA_WRITE_ONLY_IMD = 8'h0B;

    // header sizes in bytes
    localparam int BTH_BYTES     = 12;
    localparam int RETH_BYTES    = 16;
    localparam int IMMDH_BYTES   = 4;
    localparam int UDP_HDR_BYTES = 8;

    localparam logic [15:0] DEFAULT_P_KEY = 16'hFFFF;

endpackage

/* rtl/roce_tx_segmenter.sv */
`timescale 1ns/1ps

module roce_tx_segmenter
    import roce_tx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       s_dma_meta_valid,
    output logic       s_dma_meta_ready,
    input  dma_len_t   dma_length,
    input  pmtu_code_t pmtu,
    input  data_t      s_axis_tdata,
    input  keep_t      s_axis_tkeep,
    input  logic       s_axis_tvalid,
    output logic       s_axis_tready,
    input  logic       hdr_busy,
    output logic       meta_load,
    output logic       pkt_start,
    output logic       pkt_first,
    output logic       pkt_last,
    output pkt_len_t   pkt_len,
    output logic       int_valid,
    output data_t      int_data,
    output keep_t      int_keep,
    output logic       int_last,
    input  logic       int_ready_early
);

    typedef enum logic [1:0] {
        IDLE,
        PKT_START,
        PKT_BODY
    } state_t;

    state_t   state;
    dma_len_t remaining;
    pkt_len_t pkt_left;
    pkt_len_t pmtu_bytes;
    pkt_len_t cur_len;
    logic     first_pkt;
    logic     meta_ready_q;
    logic     tready_q;
    logic     beat;
    logic     pkt_end;

    // codes 0..4 select 256..4096 bytes
    always_ff @(posedge clk) begin
        pmtu_bytes <= pkt_len_t'(256) << pmtu;
    end

    assign cur_len = (remaining < dma_len_t'(pmtu_bytes)) ? pkt_len_t'(remaining) : pmtu_bytes;

    // a packet's first beat waits until the previous headers are gone
    assign s_axis_tready = tready_q &&
                           ((state == PKT_START && !hdr_busy) || state == PKT_BODY);
    assign beat = s_axis_tvalid && s_axis_tready;

    assign pkt_end = (state == PKT_START) ? (cur_len <= pkt_len_t'(DATA_BYTES))
                                          : (pkt_left <= pkt_len_t'(DATA_BYTES));

    assign s_dma_meta_ready = meta_ready_q;
    assign meta_load        = s_dma_meta_valid && meta_ready_q;

    assign pkt_start = beat && (state == PKT_START);
    assign pkt_first = first_pkt;
    assign pkt_last  = remaining <= dma_len_t'(pmtu_bytes);
    assign pkt_len   = cur_len;

    assign int_valid = beat;
    assign int_data  = s_axis_tdata;
    assign int_keep  = s_axis_tkeep;
    assign int_last  = pkt_end;

    always_ff @(posedge clk) begin
        if (rst) begin
            state        <= IDLE;
            meta_ready_q <= 1'b0;
            tready_q     <= 1'b0;
            first_pkt    <= 1'b0;
            remaining    <= '0;
            pkt_left     <= '0;
        end else begin
            tready_q <= int_ready_early;
            case (state)
                IDLE: begin
                    meta_ready_q <= !hdr_busy && !meta_load;
                    if (meta_load) begin
                        remaining <= dma_length;
                        first_pkt <= 1'b1;
                        state     <= PKT_START;
                    end
                end
                PKT_START: begin
                    if (beat) begin
                        first_pkt <= 1'b0;
                        remaining <= remaining - dma_len_t'(cur_len);
                        pkt_left  <= cur_len - pkt_len_t'(DATA_BYTES);
                        if (!pkt_end) begin
                            state <= PKT_BODY;
                        end else if (pkt_last) begin
                            state <= IDLE;
                        end
                    end
                end
                PKT_BODY: begin
                    if (beat) begin
                        pkt_left <= pkt_left - pkt_len_t'(DATA_BYTES);
                        // remaining already excludes the current packet
                        if (pkt_end) begin
                            state <= (remaining == '0) ? IDLE : PKT_START;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* rtl/roce_tx_skid_buffer.sv */
`timescale 1ns/1ps

module roce_tx_skid_buffer
    import roce_tx_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  int_valid,
    input  data_t int_data,
    input  keep_t int_keep,
    input  logic  int_last,
    output logic  int_ready_early,
    output data_t m_tdata,
    output keep_t m_tkeep,
    output logic  m_tvalid,
    output logic  m_tlast,
    input  logic  m_tready
);

    data_t tmp_data;
    keep_t tmp_keep;
    logic  tmp_last;
    logic  tmp_valid;
    logic  store_out;
    logic  store_tmp;
    logic  tmp_to_out;

    // upstream may send next cycle if the sink drains or both registers are empty
    assign int_ready_early = m_tready || (!tmp_valid && !m_tvalid);

    assign store_out  = int_valid && (m_tready || !m_tvalid);
    assign store_tmp  = int_valid && !m_tready && m_tvalid;
    assign tmp_to_out = !int_valid && m_tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            m_tvalid  <= 1'b0;
            tmp_valid <= 1'b0;
        end else if (store_out) begin
            m_tvalid <= 1'b1;
        end else if (store_tmp) begin
            tmp_valid <= 1'b1;
        end else if (tmp_to_out) begin
            m_tvalid  <= tmp_valid;
            tmp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (store_out) begin
            m_tdata <= int_data;
            m_tkeep <= int_keep;
            m_tlast <= int_last;
        end else if (tmp_to_out) begin
            m_tdata <= tmp_data;
            m_tkeep <= tmp_keep;
            m_tlast <= tmp_last;
        end
        if (store_tmp) begin
            tmp_data <= int_data;
            tmp_keep <= int_keep;
            tmp_last <= int_last;
        end
    end

endmodule

/* verif/roce_tx_checker.sv */
`timescale 1ns/1ps

module roce_tx_checker
    import roce_tx_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        s_dma_meta_valid,
    input logic        s_dma_meta_ready,
    input dma_len_t    dma_length,
    input logic        s_axis_tvalid,
    input logic        s_axis_tready,
    input logic        m_roce_bth_valid,
    input logic        m_roce_bth_ready,
    input opcode_t     m_roce_bth_op_code,
    input psn_t        m_roce_bth_psn,
    input logic [15:0] m_udp_length,
    input logic        m_roce_reth_valid,
    input logic        m_roce_reth_ready,
    input vaddr_t      m_roce_reth_v_addr,
    input logic        m_roce_immdh_valid,
    input logic        m_roce_immdh_ready,
    input logic [31:0] m_roce_immdh_data,
    input logic        m_roce_payload_axis_tvalid,
    input logic        m_roce_payload_axis_tready,
    input data_t       m_roce_payload_axis_tdata,
    input logic        m_roce_payload_axis_tlast
);

    int       fails = 0;
    dma_len_t beats_left;

    // input beats of the current transfer still to come
    always_ff @(posedge clk) begin
        if (rst) begin
            beats_left <= '0;
        end else if (s_dma_meta_valid && s_dma_meta_ready) begin
            beats_left <= (dma_length + 32'd7) >> 3;
        end else if (s_axis_tvalid && s_axis_tready && beats_left != '0) begin
            beats_left <= beats_left - dma_len_t'(1);
        end
    end

    a_bth_hold: assert property (@(posedge clk) disable iff (rst)
        m_roce_bth_valid && !m_roce_bth_ready |=> m_roce_bth_valid &&
            $stable(m_roce_bth_op_code) && $stable(m_roce_bth_psn) && $stable(m_udp_length))
        else begin
            $error("bth valid or fields changed before ready");
            fails++;
        end

    a_reth_hold: assert property (@(posedge clk) disable iff (rst)
        m_roce_reth_valid && !m_roce_reth_ready |=>
            m_roce_reth_valid && $stable(m_roce_reth_v_addr))
        else begin
            $error("reth valid or fields changed before ready");
            fails++;
        end

    a_immdh_hold: assert property (@(posedge clk) disable iff (rst)
        m_roce_immdh_valid && !m_roce_immdh_ready |=>
            m_roce_immdh_valid && $stable(m_roce_immdh_data))
        else begin
            $error("immdh valid or data changed before ready");
            fails++;
        end

    a_payload_hold: assert property (@(posedge clk) disable iff (rst)
        m_roce_payload_axis_tvalid && !m_roce_payload_axis_tready |=>
            m_roce_payload_axis_tvalid && $stable(m_roce_payload_axis_tdata) &&
            $stable(m_roce_payload_axis_tlast))
        else begin
            $error("payload beat changed before ready");
            fails++;
        end

    a_meta_busy: assert property (@(posedge clk) disable iff (rst)
        s_dma_meta_ready |-> beats_left == '0)
        else begin
            $error("descriptor ready while a transfer is in flight");
            fails++;
        end

    a_reset_quiet: assert property (@(posedge clk)
        rst && $past(rst) |-> !m_roce_payload_axis_tvalid)
        else begin
            $error("payload beat presented during reset");
            fails++;
        end

endmodule

/* verif/tb_roce_tx_header_producer.sv */
`timescale 1ns/1ps

module tb_roce_tx_header_producer
    import roce_tx_pkg::*;
();

    // several cycles per beat covers random stalls, plus idle time between tests
    localparam int TOTAL_BEATS = 13 + 25 + 80 + 88 + 250 + 226;
    localparam int TIMEOUT_NS  = TOTAL_BEATS * 8 * 20 + 40000;

    logic        clk;
    logic        rst;
    logic        s_dma_meta_valid;
    logic        s_dma_meta_ready;
    dma_len_t    dma_length;
    qpn_t        rem_qpn;
    qpn_t        loc_qpn;
    psn_t        rem_psn;
    rkey_t       r_key;
    ip_addr_t    rem_ip_addr;
    udp_port_t   src_udp_port;
    vaddr_t      rem_addr;
    logic        is_immediate;
    logic [31:0] immediate_data;
    logic        transfer_type;
    data_t       s_axis_tdata;
    keep_t       s_axis_tkeep;
    logic        s_axis_tvalid;
    logic        s_axis_tready;
    logic        m_roce_bth_valid;
    logic        m_roce_bth_ready = 1'b1;
    opcode_t     m_roce_bth_op_code;
    logic [15:0] m_roce_bth_p_key;
    psn_t        m_roce_bth_psn;
    qpn_t        m_roce_bth_dest_qp;
    qpn_t        m_roce_bth_src_qp;
    logic        m_roce_bth_ack_req;
    ip_addr_t    m_ip_dest_ip;
    udp_port_t   m_udp_source_port;
    udp_port_t   m_udp_dest_port;
    logic [15:0] m_udp_length;
    logic        m_roce_reth_valid;
    logic        m_roce_reth_ready = 1'b1;
    vaddr_t      m_roce_reth_v_addr;
    rkey_t       m_roce_reth_r_key;
    dma_len_t    m_roce_reth_length;
    logic        m_roce_immdh_valid;
    logic        m_roce_immdh_ready = 1'b1;
    logic [31:0] m_roce_immdh_data;
    data_t       m_roce_payload_axis_tdata;
    keep_t       m_roce_payload_axis_tkeep;
    logic        m_roce_payload_axis_tvalid;
    logic        m_roce_payload_axis_tready = 1'b1;
    logic        m_roce_payload_axis_tlast;
    pmtu_code_t  pmtu;
    udp_port_t   roce_udp_port;

    logic stall_en = 1'b0;
    int   checks = 0;
    int   errors = 0;
    int   fails;

    logic [281:0] desc_q[$];
    logic [71:0]  src_q[$];
    int           beats_q[$];
    logic [176:0] exp_bth[$];
    logic [176:0] got_bth[$];
    logic [127:0] exp_reth[$];
    logic [127:0] got_reth[$];
    logic [31:0]  exp_immdh[$];
    logic [31:0]  got_immdh[$];
    logic [72:0]  exp_beat[$];
    logic [72:0]  got_beat[$];
    time          desc_time[$];
    time          end_time[$];

    roce_tx_header_producer u_roce_tx_header_producer (.*);

    bind roce_tx_header_producer roce_tx_checker u_checker (.*);

    initial clk = 1'b0;
    always #10 clk = !clk;

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the DUT stopped making progress before all tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

    // outputs are stable at the falling edge and transfer on the next rising edge
    always @(negedge clk) begin
        if (!rst) begin
            if (m_roce_bth_valid && m_roce_bth_ready) begin
                got_bth.push_back({m_roce_bth_op_code, m_roce_bth_p_key, m_roce_bth_psn,
                                   m_roce_bth_dest_qp, m_roce_bth_src_qp, m_roce_bth_ack_req,
                                   m_ip_dest_ip, m_udp_source_port, m_udp_dest_port,
                                   m_udp_length});
            end
            if (m_roce_reth_valid && m_roce_reth_ready) begin
                got_reth.push_back({m_roce_reth_v_addr, m_roce_reth_r_key, m_roce_reth_length});
            end
            if (m_roce_immdh_valid && m_roce_immdh_ready) begin
                got_immdh.push_back(m_roce_immdh_data);
            end
            if (m_roce_payload_axis_tvalid && m_roce_payload_axis_tready) begin
                got_beat.push_back({m_roce_payload_axis_tdata, m_roce_payload_axis_tkeep,
                                    m_roce_payload_axis_tlast});
            end
        end
    end

    always @(posedge clk) begin
        #1;
        m_roce_payload_axis_tready = !stall_en || ($urandom_range(3) != 0);
        m_roce_bth_ready           = !stall_en || ($urandom_range(3) != 0);
        m_roce_reth_ready          = !stall_en || ($urandom_range(3) != 0);
        m_roce_immdh_ready         = !stall_en || ($urandom_range(3) != 0);
    end

    task automatic check_val(input string what, input logic [255:0] got,
                             input logic [255:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("ERR %0t ns: %s got %0h expected %0h", $time, what, got, want);
        end
    endtask

    // opcode offsets run first, middle, last, last imm, only, only imm
    function automatic opcode_t opcode_for(logic wr, logic imm, logic first, logic last);
        opcode_t base;
        base = wr ? 8'h06 : 8'h00;
        if (first && last) begin
            return base + (imm ? 8'h05 : 8'h04);
        end
        if (first) begin
            return base;
        end
        if (last) begin
            return base + (imm ? 8'h03 : 8'h02);
        end
        return base + 8'h01;
    endfunction

    task automatic add_transfer(input int len, input logic wr, input logic imm, input psn_t psn0);
        qpn_t        rq;
        qpn_t        lq;
        rkey_t       rk;
        ip_addr_t    ip;
        udp_port_t   sp;
        vaddr_t      va;
        logic [31:0] idata;
        int          mtu;
        int          rem;
        int          idx;
        int          beat;
        int          plen;
        int          nb;
        int          bytes;
        int          ulen;
        logic        first;
        logic        last;
        logic        lastb;
        data_t       w;
        keep_t       kp;
        rq    = qpn_t'($urandom);
        lq    = qpn_t'($urandom);
        rk    = $urandom;
        ip    = $urandom;
        sp    = udp_port_t'($urandom);
        va    = {$urandom, $urandom};
        idata = $urandom;
        desc_q.push_back({dma_len_t'(len), rq, lq, psn0, rk, ip, sp, va, imm, idata, wr});
        mtu  = 256 << pmtu;
        rem  = len;
        idx  = 0;
        beat = 0;
        while (rem > 0) begin
            plen  = (rem < mtu) ? rem : mtu;
            first = (idx == 0);
            last  = (rem <= mtu);
            // udp header 8 plus bth 12, reth 16 and immdh 4 when present
            ulen = plen + 20 + ((wr && first) ? 16 : 0) + ((imm && last) ? 4 : 0);
            exp_bth.push_back({opcode_for(wr, imm, first, last), 16'hFFFF,
                               psn_t'(psn0 + psn_t'(idx)), rq, lq, 1'b1, ip, sp,
                               roce_udp_port, 16'(ulen)});
            if (wr && first) begin
                exp_reth.push_back({va, rk, dma_len_t'(len)});
            end
            if (imm && last) begin
                exp_immdh.push_back(idata);
            end
            nb = (plen + 7) / 8;
            for (int i = 0; i < nb; i++) begin
                bytes = len - 8 * beat;
                kp    = (bytes >= 8) ? 8'hFF : keep_t'((1 << bytes) - 1);
                w     = {$urandom, $urandom};
                lastb = (i == nb - 1);
                src_q.push_back({w, kp});
                exp_beat.push_back({w, kp, lastb});
                beat++;
            end
            rem -= plen;
            idx++;
        end
        beats_q.push_back(beat);
    endtask

    task automatic drive_descs();
        for (int i = 0; i < desc_q.size(); i++) begin
            {dma_length, rem_qpn, loc_qpn, rem_psn, r_key, rem_ip_addr, src_udp_port,
             rem_addr, is_immediate, immediate_data, transfer_type} = desc_q[i];
            s_dma_meta_valid = 1'b1;
            do @(negedge clk); while (!s_dma_meta_ready);
            desc_time.push_back($time);
            @(posedge clk);
            #1;
            s_dma_meta_valid = 1'b0;
        end
    endtask

    task automatic drive_payload();
        for (int t = 0; t < beats_q.size(); t++) begin
            for (int b = 0; b < beats_q[t]; b++) begin
                {s_axis_tdata, s_axis_tkeep} = src_q.pop_front();
                s_axis_tvalid = 1'b1;
                do @(negedge clk); while (!s_axis_tready);
                if (b == beats_q[t] - 1) begin
                    end_time.push_back($time);
                end
                @(posedge clk);
                #1;
            end
        end
        s_axis_tvalid = 1'b0;
    endtask

    task automatic run_queued(input int num, input string name);
        int errs_before;
        errs_before = errors;
        desc_time.delete();
        end_time.delete();
        fork
            drive_descs();
            drive_payload();
        join
        while (got_beat.size() < exp_beat.size() || got_bth.size() < exp_bth.size() ||
               got_reth.size() < exp_reth.size() || got_immdh.size() < exp_immdh.size()) begin
            @(posedge clk);
        end
        // a few idle cycles so that any extra header or beat is seen
        repeat (5) @(posedge clk);
        check_val({name, " bth count"}, 256'(got_bth.size()), 256'(exp_bth.size()));
        check_val({name, " reth count"}, 256'(got_reth.size()), 256'(exp_reth.size()));
        check_val({name, " immdh count"}, 256'(got_immdh.size()), 256'(exp_immdh.size()));
        check_val({name, " beat count"}, 256'(got_beat.size()), 256'(exp_beat.size()));
        for (int i = 0; i < exp_bth.size() && i < got_bth.size(); i++) begin
            check_val($sformatf("%s bth %0d", name, i), 256'(got_bth[i]), 256'(exp_bth[i]));
        end
        for (int i = 0; i < exp_reth.size() && i < got_reth.size(); i++) begin
            check_val($sformatf("%s reth %0d", name, i), 256'(got_reth[i]), 256'(exp_reth[i]));
        end
        for (int i = 0; i < exp_immdh.size() && i < got_immdh.size(); i++) begin
            check_val($sformatf("%s immdh %0d", name, i), 256'(got_immdh[i]),
                      256'(exp_immdh[i]));
        end
        for (int i = 0; i < exp_beat.size() && i < got_beat.size(); i++) begin
            check_val($sformatf("%s beat %0d", name, i), 256'(got_beat[i]), 256'(exp_beat[i]));
        end
        // a later descriptor is taken only after the previous transfer's final beat
        for (int i = 1; i < desc_time.size() && i <= end_time.size(); i++) begin
            check_val($sformatf("%s descriptor %0d after previous transfer end", name, i),
                      256'(desc_time[i] > end_time[i-1]), 256'(1));
        end
        $display("test %0d %s: %0d errors", num, name, errors - errs_before);
        desc_q.delete();
        beats_q.delete();
        exp_bth.delete();
        got_bth.delete();
        exp_reth.delete();
        got_reth.delete();
        exp_immdh.delete();
        got_immdh.delete();
        exp_beat.delete();
        got_beat.delete();
    endtask

    task automatic start_test(input pmtu_code_t code);
        @(posedge clk);
        #1;
        pmtu = code;
        @(posedge clk);
        #1;
    endtask

    initial begin
        void'($urandom(2));
        rst              = 1'b1;
        s_dma_meta_valid = 1'b0;
        dma_length       = '0;
        rem_qpn          = '0;
        loc_qpn          = '0;
        rem_psn          = '0;
        r_key            = '0;
        rem_ip_addr      = '0;
        src_udp_port     = '0;
        rem_addr         = '0;
        is_immediate     = 1'b0;
        immediate_data   = '0;
        transfer_type    = 1'b0;
        s_axis_tdata     = '0;
        s_axis_tkeep     = '0;
        s_axis_tvalid    = 1'b0;
        pmtu             = 3'd1;
        roce_udp_port    = 16'd4791;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test(3'd1);
        add_transfer(100, 1'b0, 1'b0, 24'h000123);
        run_queued(1, "send single");

        start_test(3'd1);
        add_transfer(200, 1'b1, 1'b1, 24'h00ABCD);
        run_queued(2, "write single imm");

        start_test(3'd0);
        add_transfer(640, 1'b0, 1'b0, 24'h000010);
        run_queued(3, "send three packets");

        start_test(3'd0);
        add_transfer(700, 1'b1, 1'b1, 24'hFFFFFF);
        run_queued(4, "write imm psn wrap");

        stall_en = 1'b1;
        start_test(3'd1);
        add_transfer(2000, 1'b1, 1'b0, 24'h200000);
        run_queued(5, "write with stalls");
        stall_en = 1'b0;

        start_test(3'd2);
        add_transfer(1500, 1'b0, 1'b1, 24'h000500);
        add_transfer(300, 1'b1, 1'b1, 24'h777777);
        run_queued(6, "back to back");

        fails = u_roce_tx_header_producer.u_checker.fails;
        $display("tests 6, checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, fails);
        if (errors == 0 && fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* verilog.f */
rtl/roce_tx_pkg.sv
rtl/roce_tx_segmenter.sv
rtl/roce_tx_header_gen.sv
rtl/roce_tx_skid_buffer.sv
rtl/roce_tx_header_producer.sv
verif/roce_tx_checker.sv
verif/tb_roce_tx_header_producer.sv
